/* hdl/rv_pkg.sv */
// shared core definitions
// opcode constants, decoder field encodings, ALU control enum, FSM states
package rv_pkg;

    localparam int XLEN = 32; // data width

    localparam logic [6:0] OP_LOAD   = 7'b0000011; // lw
    localparam logic [6:0] OP_IMM    = 7'b0010011; // addi .. srai
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_STORE  = 7'b0100011; // sw
    localparam logic [6:0] OP_REG    = 7'b0110011; // add .. and
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;

    localparam logic [1:0] RES_ALU   = 2'b00; // writeback from alu
    localparam logic [1:0] RES_MEM   = 2'b01; // from ram
    localparam logic [1:0] RES_PC4   = 2'b10; // link value
    localparam logic [1:0] RES_UPPER = 2'b11; // upper-immediate adder

    localparam logic [2:0] IMM_I     = 3'b000;
    localparam logic [2:0] IMM_S     = 3'b001;
    localparam logic [2:0] IMM_B     = 3'b010; // 13 bit, lsb zero
    localparam logic [2:0] IMM_J     = 3'b011; // 21 bit, lsb zero
    localparam logic [2:0] IMM_U     = 3'b100; // upper 20 bits
    localparam logic [2:0] IMM_SHAMT = 3'b101; // zero-extended shamt

    localparam logic [1:0] ALUOP_ADD    = 2'b00; // address add
    localparam logic [1:0] ALUOP_BRANCH = 2'b01; // compare only
    localparam logic [1:0] ALUOP_FUNCT  = 2'b10; // r-type
    localparam logic [1:0] ALUOP_IMM    = 2'b11; // i-type, funct7 for shifts only

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_ctrl_e;

    typedef enum logic [1:0] {FETCH, EXEC, MEM, WB} core_state_e;

endpackage

/* hdl/signal_controller.sv */
// main decoder, opcode and funct3 to datapath control fields
`timescale 1ns/1ns
module signal_controller import rv_pkg::*; (
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,     // picks shamt form for shifts
    output logic [1:0] result_src,
    output logic       mem_write,
    output logic       alu_src,    // 1: immediate as operand b
    output logic [2:0] imm_src,
    output logic       reg_write,
    output logic [1:0] alu_op,
    output logic       mreq,       // data memory access
    output logic       is_branch,
    output logic       jump,
    output logic       is_utype,
    output logic       is_lui,
    output logic       is_jalr,
    output logic       illegal
);

    // word: res_mw_as_imm_rw_aluop_mreq_br_j_ut_lui_jalr_ill
    function automatic logic [16:0] main_decoder(input logic [6:0] op, input logic [2:0] f3);
        logic [2:0] isrc;
        isrc = (f3 == 3'b001 || f3 == 3'b101) ? IMM_SHAMT : IMM_I; // slli, srli, srai
        case (op)
            OP_LOAD:   main_decoder = {RES_MEM, 2'b01, IMM_I, 1'b1, ALUOP_ADD, 7'b1000000};
            OP_IMM:    main_decoder = {RES_ALU, 2'b01, isrc, 1'b1, ALUOP_IMM, 7'b0000000};
            OP_JALR:   main_decoder = {RES_PC4, 2'b01, IMM_I, 1'b1, ALUOP_ADD, 7'b0010010};
            OP_STORE:  main_decoder = {RES_ALU, 2'b11, IMM_S, 1'b0, ALUOP_ADD, 7'b1000000};
            OP_REG:    main_decoder = {RES_ALU, 2'b00, IMM_I, 1'b1, ALUOP_FUNCT, 7'b0000000};
            OP_BRANCH: main_decoder = {RES_ALU, 2'b00, IMM_B, 1'b0, ALUOP_BRANCH, 7'b0100000};
            OP_JAL:    main_decoder = {RES_PC4, 2'b00, IMM_J, 1'b1, ALUOP_ADD, 7'b0010000};
            OP_AUIPC:  main_decoder = {RES_UPPER, 2'b01, IMM_U, 1'b1, ALUOP_ADD, 7'b0001000};
            OP_LUI:    main_decoder = {RES_UPPER, 2'b01, IMM_U, 1'b1, ALUOP_ADD, 7'b0001100};
            default:   main_decoder = 17'b1; // undefined, nothing active
        endcase
    endfunction

    assign {result_src, mem_write, alu_src, imm_src, reg_write, alu_op, mreq,
            is_branch, jump, is_utype, is_lui, is_jalr, illegal} = main_decoder(opcode, funct3);

    // a store request always goes out as a memory access
    always_comb begin
        assert (!(mem_write && !mreq));
    end

endmodule

/* hdl/alu_unit.sv */
// alu control decode from op class and function bits
// arithmetic, logic and shift result, compare flags for branches
`timescale 1ns/1ns
module alu_unit import rv_pkg::*; (
    input  logic [1:0]      alu_op,
    input  logic [2:0]      funct3,
    input  logic            funct7_b5,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] result,
    output logic            eq,
    output logic            lt,     // signed
    output logic            ltu     // unsigned
);

    alu_ctrl_e alu_ctrl;

    always_comb begin
        case (alu_op)
            ALUOP_ADD:    alu_ctrl = ALU_ADD;
            ALUOP_BRANCH: alu_ctrl = ALU_SUB;
            default: begin
                case (funct3)
                    3'b000:  alu_ctrl = (alu_op == ALUOP_FUNCT && funct7_b5) ? ALU_SUB : ALU_ADD;
                    3'b001:  alu_ctrl = ALU_SLL;
                    3'b010:  alu_ctrl = ALU_SLT;
                    3'b011:  alu_ctrl = ALU_SLTU;
                    3'b100:  alu_ctrl = ALU_XOR;
                    3'b101:  alu_ctrl = funct7_b5 ? ALU_SRA : ALU_SRL; // both classes
                    3'b110:  alu_ctrl = ALU_OR;
                    default: alu_ctrl = ALU_AND;
                endcase
            end
        endcase
    end

    assign eq  = (a == b);
    assign lt  = ($signed(a) < $signed(b));
    assign ltu = (a < b);

    always_comb begin
        case (alu_ctrl)
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << b[4:0];
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, ltu};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> b[4:0];
            ALU_SRA:  result = $unsigned($signed(a) >>> b[4:0]);
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = a + b;
        endcase
    end

    // an immediate bit 10 must never turn addi into a subtract
    always_comb begin
        assert (!(alu_op == ALUOP_IMM && alu_ctrl == ALU_SUB));
    end

endmodule

/* hdl/core_datapath.sv */
// instruction register, pc register, register file x1..x31
// immediate extender, operand and writeback selection
// branch resolution, next pc, retire record
`timescale 1ns/1ns
module core_datapath import rv_pkg::*; #(
    parameter int          DMEM_WORDS = 256,
    parameter logic [31:0] RESET_PC   = 32'h0,
    localparam int         AW         = $clog2(DMEM_WORDS)
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic [31:0]     instr,
    input  logic [1:0]      result_src,
    input  logic            mem_write,
    input  logic            alu_src,
    input  logic [2:0]      imm_src,
    input  logic            reg_write,
    input  logic            is_branch,
    input  logic            jump,
    input  logic            is_utype,
    input  logic            is_lui,
    input  logic            is_jalr,
    input  logic            ir_load,
    input  logic            exec_en,
    input  logic            rf_we,
    input  logic            pc_we,
    input  logic [XLEN-1:0] dmem_rdata,
    input  logic [XLEN-1:0] alu_result,
    input  logic            alu_eq,
    input  logic            alu_lt,
    input  logic            alu_ltu,
    output logic [6:0]      opcode,
    output logic [2:0]      funct3,
    output logic            alu_op_funct7,  // funct7 bit 5
    output logic [XLEN-1:0] alu_a,
    output logic [XLEN-1:0] alu_b,
    output logic [XLEN-1:0] pc,
    output logic [AW+1:0]   dmem_addr,      // byte address
    output logic [XLEN-1:0] dmem_wdata,
    output logic            dmem_we,
    output logic [XLEN-1:0] retire_pc,
    output logic            retire_we,
    output logic [4:0]      retire_rd,
    output logic [XLEN-1:0] retire_data
);

    logic [31:0]     ir;
    logic [XLEN-1:0] regs [1:31];
    logic [XLEN-1:0] rs1_val, rs2_val, imm, upper_sum, wb_data, pc4;
    logic [XLEN-1:0] alu_q;                  // result held from exec
    logic            taken, taken_q;
    logic [4:0]      rd;

    assign opcode        = ir[6:0];
    assign funct3        = ir[14:12];
    assign alu_op_funct7 = ir[30];
    assign rd            = ir[11:7];

    assign rs1_val = (ir[19:15] == 5'd0) ? '0 : regs[ir[19:15]]; // x0 reads zero
    assign rs2_val = (ir[24:20] == 5'd0) ? '0 : regs[ir[24:20]];

    always_comb begin
        case (imm_src)
            IMM_S:     imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            IMM_B:     imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            IMM_J:     imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
            IMM_U:     imm = {ir[31:12], 12'b0};
            IMM_SHAMT: imm = {27'b0, ir[24:20]};
            default:   imm = {{20{ir[31]}}, ir[31:20]};
        endcase
    end

    assign alu_a     = rs1_val;
    assign alu_b     = alu_src ? imm : rs2_val;
    assign upper_sum = ((is_utype && !is_lui) ? pc : '0) + imm; // auipc adds pc, lui zero
    assign pc4       = pc + 32'd4;

    always_comb begin
        case (funct3)
            3'b000:  taken = alu_eq;   // beq
            3'b001:  taken = !alu_eq;  // bne
            3'b100:  taken = alu_lt;   // blt
            3'b101:  taken = !alu_lt;  // bge
            3'b110:  taken = alu_ltu;  // bltu
            3'b111:  taken = !alu_ltu; // bgeu
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (result_src)
            RES_MEM:   wb_data = dmem_rdata;
            RES_PC4:   wb_data = pc4;
            RES_UPPER: wb_data = upper_sum;
            default:   wb_data = alu_q;
        endcase
    end

    assign dmem_addr  = alu_q[AW+1:0];
    assign dmem_wdata = rs2_val;
    assign dmem_we    = mem_write;

    assign retire_pc   = pc;
    assign retire_we   = reg_write && (rd != 5'd0);
    assign retire_rd   = rd;
    assign retire_data = retire_we ? wb_data : '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ir      <= '0;
            pc      <= RESET_PC;
            alu_q   <= '0;
            taken_q <= 1'b0;
            for (int i = 1; i < 32; i++) regs[i] <= '0;
        end else begin
            if (ir_load) ir <= instr;                     // transfer edge
            if (exec_en) begin
                alu_q   <= alu_result;
                taken_q <= is_branch && taken;
            end
            if (rf_we && retire_we) regs[rd] <= wb_data;  // end of wb
            if (pc_we) begin
                if (is_jalr)             pc <= alu_q & ~32'd1; // rs1+imm, bit 0 cleared
                else if (jump || taken_q) pc <= pc + imm;
                else                     pc <= pc4;
            end
        end
    end

endmodule

/* hdl/core_fsm.sv */
// fetch, execute, memory, writeback sequencer
// instruction handshake, enables, retire pulse and illegal flag
`timescale 1ns/1ns
module core_fsm import rv_pkg::*; (
    input  logic clk,
    input  logic arst_n,
    input  logic instr_valid,
    input  logic mreq,
    input  logic illegal,
    input  logic timer_done,
    output logic instr_ready,
    output logic ir_load,
    output logic exec_en,
    output logic mem_en,
    output logic timer_start,
    output logic rf_we,
    output logic pc_we,
    output logic retire_valid,
    output logic retire_illegal
);

    core_state_e state, state_nx;

    always_comb begin
        state_nx = state;
        case (state)
            FETCH:   if (instr_valid) state_nx = EXEC;  // hold while no instruction
            EXEC:    state_nx = (mreq && !illegal) ? MEM : WB;
            MEM:     if (timer_done) state_nx = WB;     // last wait cycle
            default: state_nx = FETCH;
        endcase
    end

    assign instr_ready  = (state == FETCH);
    assign ir_load      = (state == FETCH) && instr_valid;
    assign exec_en      = (state == EXEC);
    assign mem_en       = (state == MEM) && timer_done; // ram touched once
    assign rf_we        = (state == WB);
    assign pc_we        = (state == WB);
    assign retire_valid = (state == WB);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state          <= FETCH;
            timer_start    <= 1'b0;
            retire_illegal <= 1'b0;
        end else begin
            state       <= state_nx;
            timer_start <= (state == EXEC) && mreq && !illegal; // first mem cycle
            if (state == EXEC) retire_illegal <= illegal;
        end
    end

    // a retire never overlaps the next handshake
    assert property (@(posedge clk) disable iff (!arst_n) !(instr_ready && retire_valid));
    // pc moves only in wb, reached from exec or mem
    assert property (@(posedge clk) disable iff (!arst_n)
        pc_we |-> state == WB && $past(state) inside {EXEC, MEM});

endmodule

/* hdl/mem_wait_timer.sv */
// wait-state down-counter for data accesses
`timescale 1ns/1ns
module mem_wait_timer #(
    parameter int MEM_WAIT = 2
) (
    input  logic clk,
    input  logic arst_n,
    input  logic timer_start,
    output logic timer_done
);

    localparam int CW = $clog2(MEM_WAIT + 2);

    logic [CW-1:0] cnt; // zero when idle

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)               cnt <= '0;
        else if (timer_start)      cnt <= CW'(MEM_WAIT);
        else if (cnt != '0)        cnt <= cnt - 1'b1;
    end

    // zero waits finish in the start cycle
    assign timer_done = (cnt == CW'(1)) || (MEM_WAIT == 0 && timer_start);

    // no restart while a count runs
    assert property (@(posedge clk) disable iff (!arst_n) timer_start |-> cnt == '0);

endmodule

/* hdl/data_ram.sv */
// word-addressed data memory
// synchronous write, registered read
`timescale 1ns/1ns
module data_ram import rv_pkg::*; #(
    parameter int DMEM_WORDS = 256,
    localparam int AW        = $clog2(DMEM_WORDS)
) (
    input  logic            clk,
    input  logic            mem_en,
    input  logic            dmem_we,
    input  logic [AW+1:0]   dmem_addr,  // byte address
    input  logic [XLEN-1:0] dmem_wdata,
    output logic [XLEN-1:0] dmem_rdata
);

    logic [XLEN-1:0] mem [DMEM_WORDS];
    logic [AW-1:0]   idx;

    assign idx = dmem_addr[AW+1:2]; // word index, wraps at depth

    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (dmem_we) mem[idx] <= dmem_wdata;
            dmem_rdata <= mem[idx]; // seen in wb
        end
    end

endmodule

/* hdl/rv_core_top.sv */
// multicycle rv32i core top level
// decoder, alu, datapath, sequencer, wait timer and data ram
`timescale 1ns/1ns
module rv_core_top import rv_pkg::*; #(
    parameter int          MEM_WAIT   = 2,
    parameter int          DMEM_WORDS = 256,
    parameter logic [31:0] RESET_PC   = 32'h0
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            instr_valid,
    input  logic [31:0]     instr,
    output logic            instr_ready,
    output logic [XLEN-1:0] pc,
    output logic            retire_valid,
    output logic [XLEN-1:0] retire_pc,
    output logic            retire_we,
    output logic [4:0]      retire_rd,
    output logic [XLEN-1:0] retire_data,
    output logic            retire_illegal
);

    localparam int AW = $clog2(DMEM_WORDS);

    logic [6:0]      opcode;
    logic [2:0]      funct3, imm_src;
    logic [1:0]      result_src, alu_op;
    logic            funct7_b5, mem_write, alu_src, reg_write, mreq;
    logic            is_branch, jump, is_utype, is_lui, is_jalr, illegal;
    logic [XLEN-1:0] alu_a, alu_b, alu_result, dmem_wdata, dmem_rdata;
    logic            alu_eq, alu_lt, alu_ltu;
    logic            ir_load, exec_en, mem_en, timer_start, timer_done, rf_we, pc_we;
    logic [AW+1:0]   dmem_addr;
    logic            dmem_we;

    signal_controller u_ctrl (
        .opcode, .funct3, .result_src, .mem_write, .alu_src, .imm_src, .reg_write,
        .alu_op, .mreq, .is_branch, .jump, .is_utype, .is_lui, .is_jalr, .illegal
    );

    alu_unit u_alu (
        .alu_op, .funct3, .funct7_b5, .a(alu_a), .b(alu_b),
        .result(alu_result), .eq(alu_eq), .lt(alu_lt), .ltu(alu_ltu)
    );

    core_datapath #(.DMEM_WORDS(DMEM_WORDS), .RESET_PC(RESET_PC)) u_dp (
        .clk, .arst_n, .instr, .result_src, .mem_write, .alu_src, .imm_src, .reg_write,
        .is_branch, .jump, .is_utype, .is_lui, .is_jalr, .ir_load, .exec_en, .rf_we,
        .pc_we, .dmem_rdata, .alu_result, .alu_eq, .alu_lt, .alu_ltu, .opcode, .funct3,
        .alu_op_funct7(funct7_b5), .alu_a, .alu_b, .pc, .dmem_addr, .dmem_wdata,
        .dmem_we, .retire_pc, .retire_we, .retire_rd, .retire_data
    );

    core_fsm u_fsm (
        .clk, .arst_n, .instr_valid, .mreq, .illegal, .timer_done, .instr_ready,
        .ir_load, .exec_en, .mem_en, .timer_start, .rf_we, .pc_we, .retire_valid,
        .retire_illegal
    );

    mem_wait_timer #(.MEM_WAIT(MEM_WAIT)) u_timer (
        .clk, .arst_n, .timer_start, .timer_done
    );

    data_ram #(.DMEM_WORDS(DMEM_WORDS)) u_ram (
        .clk, .mem_en, .dmem_we, .dmem_addr, .dmem_wdata, .dmem_rdata
    );

endmodule

/* tb/tb_core.sv */
// testbench for rv_core_top
// instruction rom model, clock, reset, watchdog
// directed tests: alu, upper immediates, memory, branches, stalls, illegal
`timescale 1ns/1ns
module tb_core import rv_pkg::*;;

    localparam int MEM_WAIT     = 2;
    localparam int MEM_LAT      = 3 + MEM_WAIT;  // transfer to retire, lw and sw
    localparam int CLK_NS       = 8;
    localparam int ROM_WORDS    = 1024;
    localparam int N_INSTR      = 67;            // all tests together
    localparam int WATCHDOG_CYC = N_INSTR * (6 + MEM_WAIT) + 200;
    localparam logic [31:0] SEED = 32'h35ef_e605;

    logic        clk = 1'b0;
    logic        arst_n, instr_valid, instr_ready;
    logic [31:0] instr, pc, retire_pc, retire_data;
    logic        retire_valid, retire_we, retire_illegal;
    logic [4:0]  retire_rd;

    logic [31:0] rom [ROM_WORDS];
    logic [31:0] load_ptr;                        // where the next instruction goes
    logic [31:0] exp_pc[$], exp_data[$];
    logic [4:0]  exp_rd[$];
    bit          exp_we[$], exp_ill[$];
    int          exp_lat[$];
    int          errors, tests_run, tests_failed;

    rv_core_top #(.MEM_WAIT(MEM_WAIT)) dut0 (
        .clk, .arst_n, .instr_valid, .instr, .instr_ready, .pc, .retire_valid,
        .retire_pc, .retire_we, .retire_rd, .retire_data, .retire_illegal
    );

    always #(CLK_NS / 2) clk = ~clk;

    function automatic logic [31:0] r_type(input logic [2:0] f3, input logic f7b5,
                                           input logic [4:0] rd, rs1, rs2);
        return {1'b0, f7b5, 5'b0, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
                                           input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [4:0] rs1, rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE}; // sw only
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                           input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input logic [6:0] op, input logic [4:0] rd,
                                           input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    // place one instruction and the retire record it must produce
    task automatic emit(input logic [31:0] ins, input bit we, input logic [4:0] rd,
                        input logic [31:0] data, input bit ill = 1'b0, input int lat = 2);
        rom[load_ptr[11:2]] = ins;
        exp_pc.push_back(load_ptr);
        exp_we.push_back(we);
        exp_rd.push_back(rd);
        exp_data.push_back(data);
        exp_ill.push_back(ill);
        exp_lat.push_back(lat);
        load_ptr += 4;
    endtask

    task automatic report_mismatch(input string name, input string field,
                                   input logic [31:0] expv, input logic [31:0] actv);
        $display("CHECK FAILED %s %s expected %h actual %h", name, field, expv, actv);
        errors++;
    endtask

    // feeds the rom on falling edges until every expected retire was seen
    task automatic run_test(input string name, input bit gaps);
        int cyc, xfer_cyc, idx, gap, errs_before;
        errs_before = errors;
        cyc = 0;
        xfer_cyc = 0;
        idx = 0;
        gap = 0;
        while (idx < exp_pc.size()) begin
            @(negedge clk);
            cyc++;
            if (retire_valid) begin
                if (retire_pc !== exp_pc[idx])
                    report_mismatch(name, "retire_pc", exp_pc[idx], retire_pc);
                if (retire_we !== exp_we[idx])
                    report_mismatch(name, "retire_we", 32'(exp_we[idx]), 32'(retire_we));
                if (exp_we[idx] && retire_rd !== exp_rd[idx])
                    report_mismatch(name, "retire_rd", 32'(exp_rd[idx]), 32'(retire_rd));
                if (retire_data !== exp_data[idx])
                    report_mismatch(name, "retire_data", exp_data[idx], retire_data);
                if (retire_illegal !== exp_ill[idx])
                    report_mismatch(name, "retire_illegal", 32'(exp_ill[idx]), 32'(retire_illegal));
                if (cyc - xfer_cyc != exp_lat[idx])
                    report_mismatch(name, "latency", exp_lat[idx], cyc - xfer_cyc);
                idx++;
            end
            if (idx >= exp_pc.size()) instr_valid = 1'b0;  // program done
            else if (gaps && instr_ready && gap > 0) begin
                instr_valid = 1'b0;                          // withheld
                gap--;
            end else instr_valid = 1'b1;
            instr = rom[pc[11:2]];
            if (instr_valid && instr_ready) begin            // transfer on next rising edge
                xfer_cyc = cyc;
                if (gaps) gap = $urandom_range(3, 0);
            end
        end
        exp_pc.delete();
        exp_we.delete();
        exp_rd.delete();
        exp_data.delete();
        exp_ill.delete();
        exp_lat.delete();
        tests_run++;
        if (errors != errs_before) tests_failed++;
        $display("test %s finished with %0d mismatches", name, errors - errs_before);
    endtask

    task automatic alu_program();
        emit(i_type(OP_IMM, 3'b000, 1, 0, 12'd100), 1, 1, 100);
        emit(i_type(OP_IMM, 3'b000, 2, 0, 12'hff9), 1, 2, -7);
        emit(r_type(3'b000, 0, 3, 1, 2), 1, 3, 100 + -7);
        emit(r_type(3'b000, 1, 4, 2, 1), 1, 4, -7 - 100);  // sub
        emit(r_type(3'b100, 0, 5, 1, 2), 1, 5, 100 ^ -7);
        emit(r_type(3'b110, 0, 6, 1, 2), 1, 6, 100 | -7);
        emit(r_type(3'b111, 0, 7, 1, 2), 1, 7, 100 & -7);
        emit(r_type(3'b010, 0, 8, 2, 1), 1, 8, 1);         // -7 < 100 signed
        emit(r_type(3'b011, 0, 9, 2, 1), 1, 9, 0);         // but not unsigned
        emit(i_type(OP_IMM, 3'b001, 10, 1, 12'd4), 1, 10, 100 << 4);
        emit(i_type(OP_IMM, 3'b101, 11, 2, 12'd28), 1, 11, 32'hffff_fff9 >> 28);
        emit(i_type(OP_IMM, 3'b101, 12, 2, 12'h401), 1, 12, -7 >>> 1); // srai
        emit(i_type(OP_IMM, 3'b000, 15, 0, 12'd3), 1, 15, 3);
        emit(r_type(3'b001, 0, 13, 1, 15), 1, 13, 100 << 3);
        emit(r_type(3'b101, 0, 14, 2, 15), 1, 14, 32'hffff_fff9 >> 3);
        emit(r_type(3'b101, 1, 16, 2, 15), 1, 16, -7 >>> 3);
        emit(i_type(OP_IMM, 3'b000, 0, 1, 12'd5), 0, 0, 0);  // x0 not written
        emit(r_type(3'b000, 0, 0, 1, 2), 0, 0, 0);
    endtask

    task automatic upper_test();
        emit(u_type(OP_LUI, 17, 20'h12345), 1, 17, 32'h1234_5000);
        emit(u_type(OP_AUIPC, 18, 20'habcde), 1, 18, load_ptr + 32'habcd_e000);
        emit(u_type(OP_LUI, 19, 20'hfffff), 1, 19, 32'hffff_f000);
        run_test("upper", 1'b0);
    endtask

    task automatic memory_test();
        emit(i_type(OP_IMM, 3'b000, 20, 0, 12'h040), 1, 20, 32'h40);   // base address
        emit(u_type(OP_LUI, 21, 20'hdeadc), 1, 21, 32'hdead_c000);
        emit(i_type(OP_IMM, 3'b000, 21, 21, 12'heef), 1, 21, 32'hdead_c000 - 32'h111);
        emit(s_type(20, 21, 12'd8), 0, 0, 0, 1'b0, MEM_LAT);
        emit(s_type(20, 1, 12'd12), 0, 0, 0, 1'b0, MEM_LAT);
        emit(i_type(OP_LOAD, 3'b010, 22, 20, 12'd8), 1, 22, 32'hdead_beef, 1'b0, MEM_LAT);
        emit(i_type(OP_LOAD, 3'b010, 23, 20, 12'd12), 1, 23, 100, 1'b0, MEM_LAT);
        run_test("memory", 1'b0);
    endtask

    // branch forward by 8, a taken one skips a poison word
    task automatic branch(input logic [2:0] f3, input logic [4:0] rs1, rs2, input bit taken);
        emit(b_type(f3, rs1, rs2, 13'd8), 0, 0, 0);
        if (taken) load_ptr += 4;
    endtask

    task automatic branch_test();
        emit(i_type(OP_IMM, 3'b000, 1, 0, 12'd100), 1, 1, 100);
        emit(i_type(OP_IMM, 3'b000, 2, 0, 12'hff9), 1, 2, -7);
        branch(3'b000, 1, 1, 1);  // beq
        branch(3'b001, 1, 1, 0);  // bne
        branch(3'b001, 1, 2, 1);
        branch(3'b000, 1, 2, 0);
        branch(3'b100, 2, 1, 1);  // blt
        branch(3'b100, 1, 2, 0);
        branch(3'b101, 1, 2, 1);  // bge
        branch(3'b101, 2, 1, 0);
        branch(3'b110, 1, 2, 1);  // bltu
        branch(3'b110, 2, 1, 0);
        branch(3'b111, 2, 1, 1);  // bgeu
        branch(3'b111, 1, 2, 0);
        emit(j_type(25, 21'd8), 1, 25, load_ptr + 4);
        load_ptr += 4;
        emit(u_type(OP_AUIPC, 26, 20'h0), 1, 26, load_ptr);
        emit(i_type(OP_JALR, 3'b000, 27, 26, 12'd13), 1, 27, load_ptr + 4); // bit 0 dropped
        load_ptr += 4;
        emit(i_type(OP_IMM, 3'b000, 28, 0, 12'd1), 1, 28, 1);  // jalr lands here
        run_test("branch", 1'b0);
    endtask

    task automatic illegal_test();
        emit(32'hffff_ffff, 0, 0, 0, 1'b1);  // opcode 7f
        emit(32'h0000_0f8b, 0, 0, 0, 1'b1);  // custom-0 with rd x31
        emit(i_type(OP_IMM, 3'b000, 30, 31, 12'd0), 1, 30, 0); // x31 untouched
        run_test("illegal", 1'b0);
    endtask

    initial begin
        arst_n       = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        load_ptr     = '0;
        void'($urandom(SEED));
        for (int i = 0; i < ROM_WORDS; i++) rom[i] = {i[24:0], 7'h7f}; // illegal fill
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        if (pc !== 32'h0 || instr_ready !== 1'b1 || retire_valid !== 1'b0) begin
            $display("core not idle at pc 0 after reset");
            errors++;
        end
        alu_program();
        run_test("alu", 1'b0);
        upper_test();
        memory_test();
        branch_test();
        alu_program();
        run_test("stall", 1'b1);
        illegal_test();
        $display("tests run %0d, tests with errors %0d, mismatches %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) $display("All tests passed");
        else $display("Some tests failed");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYC * CLK_NS);
        $display("watchdog expired after %0d cycles, a retire never arrived", WATCHDOG_CYC);
        $display("Some tests failed");
        $finish;
    end

endmodule

/* list.f */
hdl/rv_pkg.sv
hdl/signal_controller.sv
hdl/alu_unit.sv
hdl/core_datapath.sv
hdl/core_fsm.sv
hdl/mem_wait_timer.sv
hdl/data_ram.sv
hdl/rv_core_top.sv
tb/tb_core.sv

/* Makefile */
# Verilator build and run for the rv32i multicycle core

VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert -Wall -Wno-fatal
PASS_MSG  ?= All tests passed

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
